/* include/lpdaq_defines.svh */
`ifndef LPDAQ_DEFINES_SVH
`define LPDAQ_DEFINES_SVH

// one converted sample from the ADC.
`define LPDAQ_SAMPLE_W 24

// buffer depth, power of two.
`define LPDAQ_FIFO_DEPTH 16

// flops per input synchronizer.
`define LPDAQ_SYNC_STAGES 2

// register byte addresses.
`define LPDAQ_REG_CTRL   4'h0
`define LPDAQ_REG_COUNT  4'h4
`define LPDAQ_REG_DATA   4'h8
`define LPDAQ_REG_STATUS 4'hC

`endif

/* design/lpdaq_pkg.sv */
`default_nettype none

`include "lpdaq_defines.svh"

package lpdaq_pkg;

    // one signed conversion result.
    typedef logic signed [`LPDAQ_SAMPLE_W-1:0] adc_sample_t;

    // register port data and address.
    typedef logic [31:0] reg_word_t;
    typedef logic [3:0]  reg_addr_t;

    // occupancy, 0 up to and including the depth.
    typedef logic [$clog2(`LPDAQ_FIFO_DEPTH):0] fifo_count_t;

    typedef logic [4:0] bit_count_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DONE
    } rx_state_t;

endpackage

`default_nettype wire

/* design/sample_read_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface sample_read_if;
    import lpdaq_pkg::*;

    logic        pop;
    adc_sample_t rd_sample;
    fifo_count_t count;
    logic        empty;
    logic        overflow;

    modport fifo_side (
        input  pop,
        output rd_sample,
        output count,
        output empty,
        output overflow
    );

    modport reader_side (
        output pop,
        input  rd_sample,
        input  count,
        input  empty,
        input  overflow
    );

endinterface

`default_nettype wire

/* design/adc_frame_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lpdaq_defines.svh"

module adc_frame_receiver (
    input  logic                  aclk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic                  sck,
    input  logic                  dout,
    input  logic                  fsync,
    output logic                  sample_valid,
    output lpdaq_pkg::adc_sample_t sample,
    output logic                  frame_error
);
    import lpdaq_pkg::*;

    localparam int STAGES = `LPDAQ_SYNC_STAGES;
    localparam bit_count_t LAST_BIT = bit_count_t'(`LPDAQ_SAMPLE_W - 1);

    logic [STAGES-1:0] sck_sync;
    logic [STAGES-1:0] dout_sync;
    logic [STAGES-1:0] fsync_sync;
    logic              sck_d;
    logic              fsync_d;
    logic              sck_rise;
    logic              fsync_rise;
    logic              dout_s;
    logic              shift_en;

    rx_state_t   state;
    bit_count_t  bit_cnt;
    adc_sample_t shift_reg;

    // bring the ADC lines into aclk, keep the last value for edges.
    always_ff @(posedge aclk) begin
        if (reset) begin
            sck_sync   <= '0;
            dout_sync  <= '0;
            fsync_sync <= '0;
            sck_d      <= 1'b0;
            fsync_d    <= 1'b0;
        end else begin
            sck_sync   <= {sck_sync[STAGES-2:0], sck};
            dout_sync  <= {dout_sync[STAGES-2:0], dout};
            fsync_sync <= {fsync_sync[STAGES-2:0], fsync};
            sck_d      <= sck_sync[STAGES-1];
            fsync_d    <= fsync_sync[STAGES-1];
        end
    end

    assign sck_rise   = sck_sync[STAGES-1] & ~sck_d;
    assign fsync_rise = fsync_sync[STAGES-1] & ~fsync_d;
    assign dout_s     = dout_sync[STAGES-1];

    // a new fsync wins over a coincident sck edge.
    assign shift_en = enable && (state == SHIFT) && !fsync_rise && sck_rise;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state       <= IDLE;
            bit_cnt     <= '0;
            frame_error <= 1'b0;
        end else begin
            frame_error <= 1'b0;
            if (!enable) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE: begin
                        if (fsync_rise) begin
                            state   <= SHIFT;
                            bit_cnt <= '0;
                        end
                    end
                    SHIFT: begin
                        if (fsync_rise) begin
                            // frame cut short, restart.
                            frame_error <= 1'b1;
                            bit_cnt     <= '0;
                        end else if (sck_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == LAST_BIT) begin
                                state <= DONE;
                            end
                        end
                    end
                    DONE: begin
                        if (fsync_rise) begin
                            state   <= SHIFT;
                            bit_cnt <= '0;
                        end else begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // msb first.
    always_ff @(posedge aclk) begin
        if (shift_en) begin
            shift_reg <= {shift_reg[`LPDAQ_SAMPLE_W-2:0], dout_s};
        end
    end

    assign sample_valid = (state == DONE);
    assign sample       = shift_reg;

    a_valid_error_exclusive: assert property (
        @(posedge aclk) disable iff (reset)
        !(sample_valid && frame_error)
    ) else $error("sample_valid and frame_error pulsed together");

endmodule

`default_nettype wire

/* design/sample_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lpdaq_defines.svh"

module sample_fifo (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   sample_valid,
    input  lpdaq_pkg::adc_sample_t sample,
    sample_read_if.fifo_side       rd
);
    import lpdaq_pkg::*;

    localparam int PTR_W = $clog2(`LPDAQ_FIFO_DEPTH);
    localparam fifo_count_t FULL_COUNT = fifo_count_t'(`LPDAQ_FIFO_DEPTH);

    adc_sample_t mem [`LPDAQ_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_count_t      count;
    logic             full;
    logic             wr_en;
    logic             overflow;

    assign full  = (count == FULL_COUNT);
    assign wr_en = sample_valid && !full;

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= sample;
        end
    end

    // pointers wrap on their own, depth is a power of two.
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= sample_valid && full;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head shows without waiting for the pop.
    assign rd.rd_sample = mem[rd_ptr];
    assign rd.count     = count;
    assign rd.empty     = (count == '0);
    assign rd.overflow  = overflow;

    a_count_bounded: assert property (
        @(posedge aclk) disable iff (reset)
        count <= FULL_COUNT
    ) else $error("fifo count above depth");

    a_no_pop_empty: assert property (
        @(posedge aclk) disable iff (reset)
        !(rd.pop && rd.empty)
    ) else $error("pop while fifo empty");

endmodule

`default_nettype wire

/* design/sample_readout.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lpdaq_defines.svh"

module sample_readout (
    input  logic                 aclk,
    input  logic                 reset,
    input  logic                 frame_error,
    input  logic                 reg_wr,
    input  logic                 reg_rd,
    input  lpdaq_pkg::reg_addr_t reg_addr,
    input  lpdaq_pkg::reg_word_t reg_wdata,
    sample_read_if.reader_side   rd,
    output logic                 enable,
    output lpdaq_pkg::reg_word_t reg_rdata,
    output logic                 reg_rvalid
);
    import lpdaq_pkg::*;

    localparam int EXT_W = 32 - `LPDAQ_SAMPLE_W;

    logic [1:0] status;
    reg_word_t  rd_word;
    reg_word_t  head_ext;

    assign head_ext = {{EXT_W{rd.rd_sample[`LPDAQ_SAMPLE_W-1]}}, rd.rd_sample};

    // data read pops the head, nothing when empty.
    assign rd.pop = reg_rd && (reg_addr == `LPDAQ_REG_DATA) && !rd.empty;

    always_comb begin
        case (reg_addr)
            `LPDAQ_REG_CTRL:   rd_word = {31'b0, enable};
            `LPDAQ_REG_COUNT:  rd_word = reg_word_t'(rd.count);
            `LPDAQ_REG_DATA:   rd_word = rd.empty ? '0 : head_ext;
            `LPDAQ_REG_STATUS: rd_word = {30'b0, status};
            default:           rd_word = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reg_rd) begin
            reg_rdata <= rd_word;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            enable     <= 1'b0;
            status     <= 2'b00;
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
            if (reg_wr && (reg_addr == `LPDAQ_REG_CTRL)) begin
                enable <= reg_wdata[0];
            end
            // write one to clear, a new event in the same cycle wins.
            if (reg_wr && (reg_addr == `LPDAQ_REG_STATUS)) begin
                status <= (status & ~reg_wdata[1:0]) | {frame_error, rd.overflow};
            end else begin
                status <= status | {frame_error, rd.overflow};
            end
        end
    end

    a_no_rd_wr_overlap: assert property (
        @(posedge aclk) disable iff (reset)
        !(reg_rd && reg_wr)
    ) else $error("register read and write in the same cycle");

endmodule

`default_nettype wire

/* design/lpdaq_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lpdaq_top (
    input  logic                 aclk,
    input  logic                 reset,
    input  logic                 sck,
    input  logic                 dout,
    input  logic                 fsync,
    input  logic                 reg_wr,
    input  logic                 reg_rd,
    input  lpdaq_pkg::reg_addr_t reg_addr,
    input  lpdaq_pkg::reg_word_t reg_wdata,
    output lpdaq_pkg::reg_word_t reg_rdata,
    output logic                 reg_rvalid
);
    import lpdaq_pkg::*;

    logic        enable;
    logic        sample_valid;
    adc_sample_t sample;
    logic        frame_error;

    sample_read_if rd_bus ();

    adc_frame_receiver u_receiver (
        .aclk         (aclk),
        .reset        (reset),
        .enable       (enable),
        .sck          (sck),
        .dout         (dout),
        .fsync        (fsync),
        .sample_valid (sample_valid),
        .sample       (sample),
        .frame_error  (frame_error)
    );

    sample_fifo u_fifo (
        .aclk         (aclk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .rd           (rd_bus.fifo_side)
    );

    sample_readout u_readout (
        .aclk        (aclk),
        .reset       (reset),
        .frame_error (frame_error),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .rd          (rd_bus.reader_side),
        .enable      (enable),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid)
    );

endmodule

`default_nettype wire

/* bench/adc_serial_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lpdaq_defines.svh"

module adc_serial_model #(
    parameter int HALF_CYCLES = 4
) (
    input  logic aclk,
    output logic sck,
    output logic dout,
    output logic fsync
);
    import lpdaq_pkg::*;

    initial begin
        sck   = 1'b0;
        dout  = 1'b0;
        fsync = 1'b0;
    end

    // lines change just after an aclk edge.
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    // frame sync master mode, msb first, dout set while sck is low.
    task automatic send_frame(input adc_sample_t value, input int nbits);
        int i;
        fsync = 1'b1;
        idle_cycles(2 * HALF_CYCLES);
        for (i = 0; i < nbits; i++) begin
            dout = value[`LPDAQ_SAMPLE_W-1-i];
            idle_cycles(HALF_CYCLES);
            sck = 1'b1;
            idle_cycles(HALF_CYCLES);
            sck = 1'b0;
        end
        idle_cycles(HALF_CYCLES);
        fsync = 1'b0;
        dout  = 1'b0;
        // fsync low long enough for the next rise to be seen.
        idle_cycles(2 * HALF_CYCLES);
    endtask

endmodule

`default_nettype wire

/* bench/lpdaq_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lpdaq_defines.svh"

module lpdaq_tb;
    import lpdaq_pkg::*;

    localparam int RVALID_LIMIT = 8;
    localparam int POLL_LIMIT   = 100;
    localparam int FULL_BITS    = `LPDAQ_SAMPLE_W;

    logic      aclk;
    logic      reset;
    logic      sck;
    logic      dout;
    logic      fsync;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    reg_word_t reg_wdata;
    reg_word_t reg_rdata;
    logic      reg_rvalid;

    integer      seed;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    adc_sample_t burst [20];

    lpdaq_top dut (
        .aclk       (aclk),
        .reset      (reset),
        .sck        (sck),
        .dout       (dout),
        .fsync      (fsync),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    adc_serial_model #(.HALF_CYCLES(4)) adc (
        .aclk  (aclk),
        .sck   (sck),
        .dout  (dout),
        .fsync (fsync)
    );

    initial begin
        aclk = 1'b0;
    end

    always #20 aclk = ~aclk;

    // signed value of the sample as a 32-bit word.
    function automatic reg_word_t widen_sample(input adc_sample_t s);
        int value;
        value = s;
        return reg_word_t'(value);
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string what, input reg_word_t got, input reg_word_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic check_count(input string what, input fifo_count_t got,
                               input fifo_count_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_word_t data);
        @(posedge aclk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge aclk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_word_t data);
        int n;
        @(posedge aclk);
        #1;
        if (reg_rvalid) begin
            $display("reg_rvalid stayed high after the previous read had ended");
            note_error();
        end
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge aclk);
        #1;
        reg_rd = 1'b0;
        n = 0;
        while (!reg_rvalid && n < RVALID_LIMIT) begin
            @(posedge aclk);
            #1;
            n++;
        end
        if (!reg_rvalid) begin
            $display("timeout: reg_rvalid never rose after a read of address %h", addr);
            note_error();
        end else if (n != 0) begin
            $display("reg_rvalid came %0d cycles late after a read of address %h", n, addr);
            note_error();
        end
        data = reg_rdata;
    endtask

    // polls the count register until it holds the wanted occupancy.
    task automatic wait_count(input fifo_count_t want);
        reg_word_t word;
        int        n;
        n = 0;
        reg_read(`LPDAQ_REG_COUNT, word);
        while (fifo_count_t'(word) != want && n < POLL_LIMIT) begin
            reg_read(`LPDAQ_REG_COUNT, word);
            n++;
        end
        if (fifo_count_t'(word) != want) begin
            $display("timeout: sample count stayed at %0d instead of reaching %0d",
                     fifo_count_t'(word), want);
            note_error();
        end
    endtask

    task automatic expect_reg(input string what, input reg_addr_t addr, input reg_word_t exp);
        reg_word_t word;
        reg_read(addr, word);
        check_word(what, word, exp);
    endtask

    task automatic expect_count(input string what, input fifo_count_t exp);
        reg_word_t word;
        reg_read(`LPDAQ_REG_COUNT, word);
        check_count(what, fifo_count_t'(word), exp);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic test_reset_values();
        expect_reg("ctrl after reset", `LPDAQ_REG_CTRL, 32'h0);
        expect_count("count after reset", 0);
        expect_reg("status after reset", `LPDAQ_REG_STATUS, 32'h0);
        expect_reg("data read when empty", `LPDAQ_REG_DATA, 32'h0);
        end_test("reset_values");
    endtask

    task automatic test_sign_extension();
        reg_write(`LPDAQ_REG_CTRL, 32'h1);
        expect_reg("ctrl enabled", `LPDAQ_REG_CTRL, 32'h1);
        adc.send_frame(24'h123456, FULL_BITS);
        wait_count(1);
        expect_reg("positive sample", `LPDAQ_REG_DATA, 32'h0012_3456);
        adc.send_frame(24'h9abcde, FULL_BITS);
        wait_count(1);
        expect_reg("negative sample", `LPDAQ_REG_DATA, 32'hff9a_bcde);
        expect_count("count after reads", 0);
        end_test("sign_extension");
    endtask

    task automatic test_order();
        int i;
        for (i = 0; i < 10; i++) begin
            burst[i] = adc_sample_t'($random(seed));
            adc.send_frame(burst[i], FULL_BITS);
        end
        wait_count(10);
        expect_count("count after burst", 10);
        for (i = 0; i < 10; i++) begin
            expect_reg("burst sample", `LPDAQ_REG_DATA, widen_sample(burst[i]));
        end
        expect_count("count after burst reads", 0);
        end_test("order");
    endtask

    task automatic test_overflow();
        int i;
        for (i = 0; i < 20; i++) begin
            burst[i] = adc_sample_t'($random(seed));
            adc.send_frame(burst[i], FULL_BITS);
        end
        wait_count(`LPDAQ_FIFO_DEPTH);
        expect_count("count when full", `LPDAQ_FIFO_DEPTH);
        expect_reg("status overflow", `LPDAQ_REG_STATUS, 32'h1);
        // the last four frames were dropped.
        for (i = 0; i < `LPDAQ_FIFO_DEPTH; i++) begin
            expect_reg("retained sample", `LPDAQ_REG_DATA, widen_sample(burst[i]));
        end
        expect_count("count after drain", 0);
        // head slot still holds an old sample here.
        expect_reg("data read when drained", `LPDAQ_REG_DATA, 32'h0);
        reg_write(`LPDAQ_REG_STATUS, 32'h1);
        expect_reg("status cleared", `LPDAQ_REG_STATUS, 32'h0);
        end_test("overflow");
    endtask

    task automatic test_enable_gating();
        int i;
        reg_write(`LPDAQ_REG_CTRL, 32'h0);
        expect_reg("ctrl disabled", `LPDAQ_REG_CTRL, 32'h0);
        for (i = 0; i < 3; i++) begin
            adc.send_frame(adc_sample_t'($random(seed)), FULL_BITS);
        end
        expect_count("count while disabled", 0);
        expect_reg("status while disabled", `LPDAQ_REG_STATUS, 32'h0);
        end_test("enable_gating");
    endtask

    task automatic test_short_frame();
        reg_write(`LPDAQ_REG_CTRL, 32'h1);
        adc.send_frame(24'h3c5a96, 10);
        adc.send_frame(24'hc0ffee, FULL_BITS);
        wait_count(1);
        expect_count("count after short frame", 1);
        expect_reg("status frame error", `LPDAQ_REG_STATUS, 32'h2);
        expect_reg("sample after short frame", `LPDAQ_REG_DATA, 32'hffc0_ffee);
        reg_write(`LPDAQ_REG_STATUS, 32'h2);
        expect_reg("status cleared", `LPDAQ_REG_STATUS, 32'h0);
        end_test("short_frame");
    endtask

    initial begin
        seed         = 32'hfc8f_851c;
        errors       = 0;
        test_errors  = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        repeat (3) @(posedge aclk);
        #1;
        reset = 1'b0;

        test_reset_values();
        test_sign_extension();
        test_order();
        test_overflow();
        test_enable_gating();
        test_short_frame();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lpdaq.f */
+incdir+include
design/lpdaq_pkg.sv
design/sample_read_if.sv
design/adc_frame_receiver.sv
design/sample_fifo.sv
design/sample_readout.sv
design/lpdaq_top.sv
bench/adc_serial_model.sv
bench/lpdaq_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lpdaq_tb \
    -f lpdaq.f --Mdir obj_dir -o lpdaq_sim

./obj_dir/lpdaq_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi
